//--- filelist.f
rtl/ip_tx_pkg.sv
rtl/ip_hdr_checksum.sv
rtl/ip_frame_serializer.sv
rtl/axis_skid_buffer.sv
rtl/ip_eth_tx.sv
test/ip_eth_tx_tb.sv

//--- rtl/axis_skid_buffer.sv
// ready toward the source is registered, so it lags the spare slot by design of one cycle
`timescale 1ns/1ps

module axis_skid_buffer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ser_valid,
    output logic                     ser_ready,
    input  ip_tx_pkg::stream_beat_t  ser_beat,
    output logic                     out_valid,
    input  logic                     out_ready,
    output ip_tx_pkg::stream_beat_t  out_beat
);

    ip_tx_pkg::stream_beat_t spare_beat;
    logic                    spare_valid;
    logic                    spare_valid_next;
    logic                    out_valid_next;
    logic                    out_free;
    logic                    in_xfer;
    logic                    load_out;
    logic                    load_spare;

    assign out_free = ~out_valid | out_ready;
    assign in_xfer  = ser_valid & ser_ready;

    always_comb begin
        out_valid_next   = out_valid & ~out_ready;
        spare_valid_next = spare_valid;
        load_out         = 1'b0;
        load_spare       = 1'b0;
        if (spare_valid) begin
            // drain the spare first
            if (out_free) begin
                load_out         = 1'b1;
                out_valid_next   = 1'b1;
                spare_valid_next = 1'b0;
            end
        end else if (in_xfer) begin
            if (out_free) begin
                load_out       = 1'b1;
                out_valid_next = 1'b1;
            end else begin
                load_spare       = 1'b1;
                spare_valid_next = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid   <= 1'b0;
            spare_valid <= 1'b0;
            ser_ready   <= 1'b0;
        end else begin
            out_valid   <= out_valid_next;
            spare_valid <= spare_valid_next;
            ser_ready   <= ~spare_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_beat <= spare_valid ? spare_beat : ser_beat;
        end
        if (load_spare) begin
            spare_beat <= ser_beat;
        end
    end

endmodule

//--- rtl/ip_eth_tx.sv
// IPv4 transmitter top; ethernet header is passed through, ethertype is not checked
`timescale 1ns/1ps

module ip_eth_tx (
    input  logic                     clk,
    input  logic                     rst,
    // header input
    input  logic                     hdr_valid,
    output logic                     hdr_ready,
    input  ip_tx_pkg::eth_hdr_t      eth_hdr,
    input  ip_tx_pkg::ip_hdr_t       ip_hdr,
    // ethernet header output
    output logic                     eth_hdr_out_valid,
    input  logic                     eth_hdr_out_ready,
    output ip_tx_pkg::eth_hdr_t      eth_hdr_out,
    // payload input
    input  logic                     payload_valid,
    output logic                     payload_ready,
    input  ip_tx_pkg::stream_beat_t  payload,
    // byte stream output
    output logic                     out_valid,
    input  logic                     out_ready,
    output ip_tx_pkg::stream_beat_t  out_beat,
    output logic                     error_payload_early_termination
);

    logic                     frame_hdr_valid;
    logic                     frame_hdr_ready;
    ip_tx_pkg::ip_frame_hdr_t frame_hdr;
    logic                     ser_valid;
    logic                     ser_ready;
    ip_tx_pkg::stream_beat_t  ser_beat;

    ip_hdr_checksum u_hdr_checksum (
        .clk               (clk),
        .rst               (rst),
        .hdr_valid         (hdr_valid),
        .hdr_ready         (hdr_ready),
        .eth_hdr           (eth_hdr),
        .ip_hdr            (ip_hdr),
        .eth_hdr_out_valid (eth_hdr_out_valid),
        .eth_hdr_out_ready (eth_hdr_out_ready),
        .eth_hdr_out       (eth_hdr_out),
        .frame_hdr_valid   (frame_hdr_valid),
        .frame_hdr_ready   (frame_hdr_ready),
        .frame_hdr         (frame_hdr)
    );

    ip_frame_serializer u_serializer (
        .clk                             (clk),
        .rst                             (rst),
        .frame_hdr_valid                 (frame_hdr_valid),
        .frame_hdr_ready                 (frame_hdr_ready),
        .frame_hdr                       (frame_hdr),
        .payload_valid                   (payload_valid),
        .payload_ready                   (payload_ready),
        .payload                         (payload),
        .ser_valid                       (ser_valid),
        .ser_ready                       (ser_ready),
        .ser_beat                        (ser_beat),
        .error_payload_early_termination (error_payload_early_termination)
    );

    axis_skid_buffer u_skid_buffer (
        .clk       (clk),
        .rst       (rst),
        .ser_valid (ser_valid),
        .ser_ready (ser_ready),
        .ser_beat  (ser_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

endmodule

//--- rtl/ip_frame_serializer.sv
// total length must be at least 21; a short payload is flagged, an overlong one is cut at length
`timescale 1ns/1ps

module ip_frame_serializer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      frame_hdr_valid,
    output logic                      frame_hdr_ready,
    input  ip_tx_pkg::ip_frame_hdr_t  frame_hdr,
    input  logic                      payload_valid,
    output logic                      payload_ready,
    input  ip_tx_pkg::stream_beat_t   payload,
    output logic                      ser_valid,
    input  logic                      ser_ready,
    output ip_tx_pkg::stream_beat_t   ser_beat,
    output logic                      error_payload_early_termination
);

    ip_tx_pkg::ser_state_t    state;
    ip_tx_pkg::ser_state_t    state_next;
    ip_tx_pkg::ip_len_t       count;
    ip_tx_pkg::ip_len_t       count_next;
    ip_tx_pkg::ip_len_t       count_inc;
    ip_tx_pkg::ip_frame_hdr_t hdr_reg;
    ip_tx_pkg::byte_t         last_byte;
    logic                     store_last;
    logic                     error_next;
    logic                     payload_xfer;

    // header in wire order, byte 0 at index 0
    ip_tx_pkg::byte_t [0:ip_tx_pkg::IP_HDR_BYTES-1] hdr_bytes;

    assign hdr_bytes = {
        ip_tx_pkg::IP_VERSION, ip_tx_pkg::IP_IHL,
        hdr_reg.hdr.dscp, hdr_reg.hdr.ecn,
        hdr_reg.hdr.length,
        hdr_reg.hdr.identification,
        hdr_reg.hdr.flags, hdr_reg.hdr.fragment_offset,
        hdr_reg.hdr.ttl,
        hdr_reg.hdr.protocol,
        hdr_reg.csum,
        hdr_reg.hdr.source_ip,
        hdr_reg.hdr.dest_ip
    };

    assign count_inc    = count + 16'd1;
    assign payload_xfer = payload_valid & payload_ready;

    always_comb begin
        state_next      = state;
        count_next      = count;
        store_last      = 1'b0;
        error_next      = 1'b0;
        ser_valid       = 1'b0;
        ser_beat        = '0;
        payload_ready   = 1'b0;
        frame_hdr_ready = (state == ip_tx_pkg::SER_IDLE);

        case (state)
            ip_tx_pkg::SER_IDLE: begin
                if (frame_hdr_valid && frame_hdr_ready) begin
                    count_next = '0;
                    state_next = ip_tx_pkg::SER_HEADER;
                end
            end
            ip_tx_pkg::SER_HEADER: begin
                ser_valid     = 1'b1;
                ser_beat.data = hdr_bytes[count[4:0]];
                if (ser_ready) begin
                    count_next = count_inc;
                    if (count_inc == ip_tx_pkg::IP_HDR_BYTES) begin
                        state_next = ip_tx_pkg::SER_PAYLOAD;
                    end
                end
            end
            ip_tx_pkg::SER_PAYLOAD: begin
                // straight pass-through, stalls with the buffer
                payload_ready = ser_ready;
                ser_valid     = payload_valid;
                ser_beat      = payload;
                if (payload.last) begin
                    if (count_inc < hdr_reg.hdr.length) begin
                        ser_beat.user = 1'b1;
                    end
                end else if (count_inc == hdr_reg.hdr.length) begin
                    // length reached without last, hold this byte back
                    ser_valid = 1'b0;
                end
                if (payload_xfer) begin
                    count_next = count_inc;
                    if (payload.last) begin
                        error_next = (count_inc < hdr_reg.hdr.length);
                        state_next = ip_tx_pkg::SER_IDLE;
                    end else if (count_inc == hdr_reg.hdr.length) begin
                        store_last = 1'b1;
                        state_next = ip_tx_pkg::SER_PAYLOAD_LAST;
                    end
                end
            end
            ip_tx_pkg::SER_PAYLOAD_LAST: begin
                // drop surplus, release held byte with the input's last
                payload_ready = ser_ready;
                ser_valid     = payload_valid & payload.last;
                ser_beat.data = last_byte;
                ser_beat.last = 1'b1;
                ser_beat.user = payload.user;
                if (payload_xfer && payload.last) begin
                    state_next = ip_tx_pkg::SER_IDLE;
                end
            end
            default: begin
                state_next = ip_tx_pkg::SER_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state                           <= ip_tx_pkg::SER_IDLE;
            count                           <= '0;
            error_payload_early_termination <= 1'b0;
        end else begin
            state                           <= state_next;
            count                           <= count_next;
            error_payload_early_termination <= error_next;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_hdr_valid && frame_hdr_ready) begin
            hdr_reg <= frame_hdr;
        end
        if (store_last) begin
            last_byte <= payload.data;
        end
    end

endmodule

//--- rtl/ip_hdr_checksum.sv
// one header in flight per slot; next header is taken only once both outputs have drained
`timescale 1ns/1ps

module ip_hdr_checksum (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      hdr_valid,
    output logic                      hdr_ready,
    input  ip_tx_pkg::eth_hdr_t       eth_hdr,
    input  ip_tx_pkg::ip_hdr_t        ip_hdr,
    output logic                      eth_hdr_out_valid,
    input  logic                      eth_hdr_out_ready,
    output ip_tx_pkg::eth_hdr_t       eth_hdr_out,
    output logic                      frame_hdr_valid,
    input  logic                      frame_hdr_ready,
    output ip_tx_pkg::ip_frame_hdr_t  frame_hdr
);

    logic                accept;
    logic                eth_valid_next;
    logic                frame_valid_next;
    ip_tx_pkg::ip_csum_t csum_calc;

    // one's-complement sum over the ten header words, checksum word as zero
    function automatic ip_tx_pkg::ip_csum_t header_csum(input ip_tx_pkg::ip_hdr_t h);
        logic [9:0][15:0] words;
        logic [19:0]      sum;
        logic [16:0]      fold;
        words = {
            {ip_tx_pkg::IP_VERSION, ip_tx_pkg::IP_IHL, h.dscp, h.ecn},
            h.length,
            h.identification,
            {h.flags, h.fragment_offset},
            {h.ttl, h.protocol},
            16'h0000,
            h.source_ip[31:16],
            h.source_ip[15:0],
            h.dest_ip[31:16],
            h.dest_ip[15:0]
        };
        sum = '0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + 20'(words[i]);
        end
        // two folds are enough for ten words
        fold = 17'(sum[15:0]) + 17'(sum[19:16]);
        fold = 17'(fold[15:0]) + 17'(fold[16]);
        return ~fold[15:0];
    endfunction

    assign accept    = hdr_valid & hdr_ready;
    assign csum_calc = header_csum(ip_hdr);

    // each slot drains on its own handshake
    assign eth_valid_next   = (eth_hdr_out_valid & ~eth_hdr_out_ready) | accept;
    assign frame_valid_next = (frame_hdr_valid & ~frame_hdr_ready) | accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_ready         <= 1'b0;
            eth_hdr_out_valid <= 1'b0;
            frame_hdr_valid   <= 1'b0;
        end else begin
            hdr_ready         <= ~eth_valid_next & ~frame_valid_next;
            eth_hdr_out_valid <= eth_valid_next;
            frame_hdr_valid   <= frame_valid_next;
        end
    end

    // header payload registers
    always_ff @(posedge clk) begin
        if (accept) begin
            eth_hdr_out    <= eth_hdr;
            frame_hdr.hdr  <= ip_hdr;
            frame_hdr.csum <= csum_calc;
        end
    end

endmodule

//--- rtl/ip_tx_pkg.sv
// shared types for the IPv4 transmitter; no IP options, header length fixed at 5 words
package ip_tx_pkg;

    // plain vectors with a meaning
    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] ip_len_t;
    typedef logic [15:0] ip_csum_t;

    localparam logic [3:0] IP_VERSION     = 4'd4;
    localparam logic [3:0] IP_IHL         = 4'd5;
    localparam ip_len_t    IP_HDR_BYTES   = 16'd20;
    // typical ethertype, passed through untouched
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

    typedef struct packed {
        mac_addr_t   dest_mac;
        mac_addr_t   src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        ip_len_t     length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        ip_addr_t    source_ip;
        ip_addr_t    dest_ip;
    } ip_hdr_t;

    // header as handed to the serializer, checksum already filled in
    typedef struct packed {
        ip_hdr_t  hdr;
        ip_csum_t csum;
    } ip_frame_hdr_t;

    // one byte-wide stream beat; valid and ready run beside it
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } stream_beat_t;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_HEADER,
        SER_PAYLOAD,
        SER_PAYLOAD_LAST
    } ser_state_t;

endpackage

//--- test/ip_eth_tx_tb.sv
// run from the project root so the data file path resolves; total length in every record >= 21
`timescale 1ns/1ps

module ip_eth_tx_tb;

    localparam int    CLK_PERIOD      = 20;
    localparam int    WD_FRAME_CYCLES = 50;
    localparam int    WD_BYTE_CYCLES  = 8;
    localparam string DATA_FILE       = "test/ip_eth_tx_testdata.txt";

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    hdr_valid;
    logic                    hdr_ready;
    ip_tx_pkg::eth_hdr_t     eth_hdr;
    ip_tx_pkg::ip_hdr_t      ip_hdr;
    logic                    eth_hdr_out_valid;
    logic                    eth_hdr_out_ready;
    ip_tx_pkg::eth_hdr_t     eth_hdr_out;
    logic                    payload_valid;
    logic                    payload_ready;
    ip_tx_pkg::stream_beat_t payload;
    logic                    out_valid;
    logic                    out_ready;
    ip_tx_pkg::stream_beat_t out_beat;
    logic                    error_payload_early_termination;

    // frames from the data file with all payload bytes back to back
    ip_tx_pkg::eth_hdr_t     eth_q[$];
    ip_tx_pkg::ip_hdr_t      ip_q[$];
    ip_tx_pkg::ip_csum_t     csum_q[$];
    int                      sent_q[$];
    logic                    user_q[$];
    logic                    short_q[$];
    ip_tx_pkg::byte_t        pay_q[$];
    ip_tx_pkg::stream_beat_t exp_q[$];

    int                      limit_cycles = 0;
    int                      out_idx = 0;
    int                      eth_idx = 0;
    int                      pay_frame = 0;
    logic                    err_pending = 1'b0;
    logic                    err_exp;

    ip_eth_tx UUT (
        .clk                             (clk),
        .rst                             (rst),
        .hdr_valid                       (hdr_valid),
        .hdr_ready                       (hdr_ready),
        .eth_hdr                         (eth_hdr),
        .ip_hdr                          (ip_hdr),
        .eth_hdr_out_valid               (eth_hdr_out_valid),
        .eth_hdr_out_ready               (eth_hdr_out_ready),
        .eth_hdr_out                     (eth_hdr_out),
        .payload_valid                   (payload_valid),
        .payload_ready                   (payload_ready),
        .payload                         (payload),
        .out_valid                       (out_valid),
        .out_ready                       (out_ready),
        .out_beat                        (out_beat),
        .error_payload_early_termination (error_payload_early_termination)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_byte(input string name, input ip_tx_pkg::byte_t exp,
                              input ip_tx_pkg::byte_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
        end
    endtask

    task automatic check_eth_hdr(input string name, input ip_tx_pkg::eth_hdr_t exp,
                                 input ip_tx_pkg::eth_hdr_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic check_csum(input string name, input ip_tx_pkg::ip_csum_t exp,
                              input ip_tx_pkg::ip_csum_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    // the 20 header bytes in wire order
    function automatic void pack_header(input ip_tx_pkg::ip_hdr_t h, input ip_tx_pkg::ip_csum_t c,
                                        output ip_tx_pkg::byte_t hb [20]);
        hb[0]  = {ip_tx_pkg::IP_VERSION, ip_tx_pkg::IP_IHL};
        hb[1]  = {h.dscp, h.ecn};
        hb[2]  = h.length[15:8];
        hb[3]  = h.length[7:0];
        hb[4]  = h.identification[15:8];
        hb[5]  = h.identification[7:0];
        hb[6]  = {h.flags, h.fragment_offset[12:8]};
        hb[7]  = h.fragment_offset[7:0];
        hb[8]  = h.ttl;
        hb[9]  = h.protocol;
        hb[10] = c[15:8];
        hb[11] = c[7:0];
        for (int i = 0; i < 4; i++) begin
            hb[12 + i] = h.source_ip[31 - 8 * i -: 8];
            hb[16 + i] = h.dest_ip[31 - 8 * i -: 8];
        end
    endfunction

    // end-around carry after every word with the checksum word skipped
    function automatic ip_tx_pkg::ip_csum_t recompute_csum(input ip_tx_pkg::byte_t hb [20]);
        int unsigned sum;
        sum = 0;
        for (int i = 0; i < 20; i += 2) begin
            if (i != 10) begin
                sum = sum + {hb[i], hb[i + 1]};
                if (sum > 32'hffff) begin
                    sum = sum - 32'hffff;
                end
            end
        end
        return ~ip_tx_pkg::ip_csum_t'(sum);
    endfunction

    task automatic load_frames;
        int          fd;
        int          n;
        int          b;
        int          sent_cnt;
        int          user_last;
        string       line;
        logic [47:0] dmac;
        logic [47:0] smac;
        logic [15:0] etype;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] len;
        logic [15:0] id;
        logic [2:0]  flags;
        logic [12:0] frag;
        logic [7:0]  ttl;
        logic [7:0]  proto;
        logic [31:0] sip;
        logic [31:0] dip;
        logic [15:0] csum;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            stop_with_failure("could not open the test data file");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %d %d", dmac, smac,
                        etype, dscp, ecn, len, id, flags, frag, ttl, proto, sip, dip, csum,
                        sent_cnt, user_last);
            if (n != 16) begin
                stop_with_failure("a header record in the test data file is malformed");
            end
            for (int k = 0; k < sent_cnt; k++) begin
                if ($fscanf(fd, "%h", b) != 1) begin
                    stop_with_failure("the test data file ends inside a payload");
                end
                pay_q.push_back(b[7:0]);
            end
            eth_q.push_back({dmac, smac, etype});
            ip_q.push_back({dscp, ecn, len, id, flags, frag, ttl, proto, sip, dip});
            csum_q.push_back(csum);
            sent_q.push_back(sent_cnt);
            user_q.push_back(user_last != 0);
        end
        $fclose(fd);
        if (eth_q.size() == 0) begin
            stop_with_failure("the test data file holds no frames");
        end
    endtask

    // header bytes then the payload cut to the length
    // last and user go on the final byte
    task automatic build_expected;
        ip_tx_pkg::byte_t        hb [20];
        ip_tx_pkg::stream_beat_t beat;
        int                      base;
        int                      room;
        int                      n_out;
        base = 0;
        for (int f = 0; f < eth_q.size(); f++) begin
            pack_header(ip_q[f], csum_q[f], hb);
            check_csum($sformatf("frame %0d checksum field", f), recompute_csum(hb), csum_q[f]);
            for (int i = 0; i < 20; i++) begin
                beat = '{data: hb[i], last: 1'b0, user: 1'b0};
                exp_q.push_back(beat);
            end
            room  = int'(ip_q[f].length) - int'(ip_tx_pkg::IP_HDR_BYTES);
            n_out = (sent_q[f] < room) ? sent_q[f] : room;
            short_q.push_back(sent_q[f] < room);
            for (int k = 0; k < n_out; k++) begin
                beat.data = pay_q[base + k];
                beat.last = (k == n_out - 1);
                beat.user = beat.last & (short_q[f] | user_q[f]);
                exp_q.push_back(beat);
            end
            base = base + sent_q[f];
            limit_cycles = limit_cycles + WD_FRAME_CYCLES + WD_BYTE_CYCLES * sent_q[f];
        end
    endtask

    task automatic drive_headers;
        int gap;
        for (int f = 0; f < eth_q.size(); f++) begin
            gap = $urandom % 4;
            if (gap != 0) begin
                hdr_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            eth_hdr   <= eth_q[f];
            ip_hdr    <= ip_q[f];
            hdr_valid <= 1'b1;
            do @(posedge clk); while (!hdr_ready);
        end
        hdr_valid <= 1'b0;
    endtask

    task automatic drive_payload;
        int                      gap;
        int                      base;
        ip_tx_pkg::stream_beat_t beat;
        base = 0;
        for (int f = 0; f < eth_q.size(); f++) begin
            for (int k = 0; k < sent_q[f]; k++) begin
                gap = $urandom % 3;
                if (gap != 0) begin
                    payload_valid <= 1'b0;
                    repeat (gap) @(posedge clk);
                end
                beat.data = pay_q[base + k];
                beat.last = (k == sent_q[f] - 1);
                beat.user = beat.last & user_q[f];
                payload       <= beat;
                payload_valid <= 1'b1;
                do @(posedge clk); while (!payload_ready);
            end
            base = base + sent_q[f];
        end
        payload_valid <= 1'b0;
    endtask

    // out_ready low about 30% of cycles
    task automatic pace_out_ready;
        forever begin
            @(posedge clk);
            out_ready <= ($urandom % 10) >= 3;
        end
    endtask

    task automatic pace_eth_ready;
        forever begin
            @(posedge clk);
            eth_hdr_out_ready <= ($urandom % 4) == 0;
        end
    endtask

    // output byte stream against the expected sequence
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (out_idx >= exp_q.size()) begin
                stop_with_failure("the output stream carries more bytes than expected");
            end
            check_byte("out_beat.data", exp_q[out_idx].data, out_beat.data);
            check_flag("out_beat.last", exp_q[out_idx].last, out_beat.last);
            check_flag("out_beat.user", exp_q[out_idx].user, out_beat.user);
            out_idx++;
        end
    end

    always @(posedge clk) begin
        if (!rst && eth_hdr_out_valid && eth_hdr_out_ready) begin
            if (eth_idx >= eth_q.size()) begin
                stop_with_failure("more ethernet headers came out than were sent");
            end
            check_eth_hdr("eth_hdr_out", eth_q[eth_idx], eth_hdr_out);
            eth_idx++;
        end
    end

    // pulse due one cycle after the last payload beat of a short frame only
    always @(posedge clk) begin
        if (!rst) begin
            if (err_pending) begin
                check_flag("error_payload_early_termination", err_exp,
                           error_payload_early_termination);
            end else begin
                check_flag("error_payload_early_termination", 1'b0,
                           error_payload_early_termination);
            end
            err_pending = 1'b0;
            if (payload_valid && payload_ready && payload.last) begin
                err_exp     = short_q[pay_frame];
                err_pending = 1'b1;
                pay_frame++;
            end
        end
    end

    initial begin
        wait (limit_cycles != 0);
        #(limit_cycles * CLK_PERIOD);
        stop_with_failure("the run hung and the watchdog expired");
    end

    initial begin
        rst               = 1'b1;
        hdr_valid         = 1'b0;
        eth_hdr           = '0;
        ip_hdr            = '0;
        eth_hdr_out_ready = 1'b0;
        payload_valid     = 1'b0;
        payload           = '0;
        out_ready         = 1'b0;
        void'($urandom(32'h1577));
        load_frames();
        build_expected();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        fork
            pace_out_ready();
            pace_eth_ready();
        join_none
        fork
            drive_headers();
            drive_payload();
        join
        while (out_idx < exp_q.size() || eth_idx < eth_q.size()) begin
            @(posedge clk);
        end
        // idle a while so stray bytes or pulses still get caught
        repeat (20) @(posedge clk);
        if (err_pending || pay_frame != eth_q.size()) begin
            stop_with_failure("not every frame's payload end was seen by the status check");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

//--- test/ip_eth_tx_testdata.txt
# dmac smac ethtype dscp ecn length id flags frag ttl proto src_ip dst_ip csum sent(dec) user(dec)
# the line after each record holds the payload bytes as sent, in hex
02000000000a 020000000001 0800 00 0 0018 1c46 2 0000 40 11 c0a80001 c0a800c7 9c76 4 0
11 22 33 44
ffffffffffff 020000000001 0800 00 0 001c 1c47 2 0000 40 11 c0a80001 c0a800c7 9c71 5 0
a0 a1 a2 a3 a4
02000000000b 020000000001 0800 2e 1 0017 beef 2 0000 40 06 c0a80001 c0a800c7 f91f 6 0
01 02 03 04 05 06
0a1b2c3d4e5f 020000000002 86dd 00 0 001a 0000 1 0123 80 01 0a000001 0a0000fe 04c2 6 1
de ad be ef 00 ff
02000000000a 020000000001 0800 00 0 0016 ffff 2 0000 40 11 c0a80001 c0a800c7 b8be 4 1
5a 5b 5c 5d
02000000000c 020000000003 0800 00 0 0015 1234 2 0000 40 11 c0a80001 c0a800c7 a68b 1 0
7e
02000000000d 020000000001 0800 00 0 0020 0001 2 0000 40 11 c0a80001 c0a800c7 b8b3 1 0
c3
